/* compile.f */
+incdir+logic
+incdir+verification
logic/rvIsaPkg.sv
logic/rvCorePkg.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/regFile.sv
logic/pcUnit.sv
logic/rvCore.sv
verification/rvCoreTb.sv

/* Makefile */
SIM := obj_dir/rvCoreSim
SRCS := $(filter-out +%,$(shell cat compile.f)) logic/rvDefs_defs.svh verification/rvCoreModel.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module rvCoreTb -f compile.f --Mdir obj_dir -o rvCoreSim

clean:
	rm -rf obj_dir

/* verification/rvCoreModel.svh */
// architectural model of the RV32I core
// register array and pc; predicts aluResult and memReq, then retires the instruction
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

logic [`RV_XLEN-1:0] modelRegs [0:`RV_REG_COUNT-1];
logic [`RV_XLEN-1:0] modelPc;

task automatic modelReset();
    int i;
    for (i = 0; i < `RV_REG_COUNT; i++)
    begin
        modelRegs[i] = '0;
    end
    modelPc = `RV_RESET_PC;
endtask

// arithmetic by funct3, alt selects sub / sra
function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;  // bgeu
    endcase
endfunction

task automatic modelStep(input logic [31:0] ins, input logic [31:0] rdata,
                         output logic [31:0] expAlu, output logic checkAlu,
                         output rvCorePkg::memReqS expReq);
    logic [2:0] f3;
    logic [4:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] wb;
    logic [31:0] nextPc;
    logic wen;
    f3 = ins[14:12];
    rd = ins[11:7];
    a = modelRegs[ins[19:15]];
    b = modelRegs[ins[24:20]];  // store data, also on lw
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    expAlu = '0;
    checkAlu = 1'b0;
    expReq = '0;
    wen = 1'b0;
    wb = '0;
    nextPc = modelPc + 32'(`RV_INSTR_BYTES);
    case (ins[6:0])
        7'b0110011:  // register-register
        begin
            expAlu = aluCalc(f3, ins[30], a, b);
            checkAlu = 1'b1;
            wen = 1'b1;
            wb = expAlu;
        end
        7'b0010011:  // imm bits are not funct7 except on shifts
        begin
            expAlu = aluCalc(f3, ins[30] && f3 == 3'b101, a, immI);
            checkAlu = 1'b1;
            wen = 1'b1;
            wb = expAlu;
        end
        7'b0000011:
        begin
            expAlu = a + immI;
            checkAlu = 1'b1;
            expReq.read = 1'b1;
            expReq.addr = expAlu;
            expReq.wdata = b;
            wen = 1'b1;
            wb = rdata;  // full word written back
        end
        7'b0100011:
        begin
            expAlu = a + immS;
            checkAlu = 1'b1;
            expReq.write = 1'b1;
            expReq.addr = expAlu;
            expReq.wdata = b;
        end
        7'b1100011:
        begin
            checkAlu = 1'b1;  // compares leave the result at zero
            if (branchCond(f3, a, b))
                nextPc = modelPc + immB;
        end
        7'b1101111:
        begin
            wen = 1'b1;
            wb = modelPc + 32'(`RV_INSTR_BYTES);
            nextPc = modelPc + immJ;
        end
        7'b1100111:
        begin
            wen = 1'b1;
            wb = modelPc + 32'(`RV_INSTR_BYTES);
            nextPc = (a + immI) & ~32'd1;
        end
        7'b0110111:
        begin
            wen = 1'b1;
            wb = {ins[31:12], 12'b0};
        end
        default: wen = 1'b0;  // illegal, plain pc step
    endcase
    if (wen && rd != 5'd0)
        modelRegs[rd] = wb;  // x0 stays zero
    modelPc = nextPc;
endtask

`endif

/* verification/rvCoreTb.sv */
// testbench for the single-cycle RV32I core
// random legal instruction stream, checked each cycle against the architectural model
`include "rvDefs_defs.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumInstr = 2000;
    localparam int ResetCycles = 16;
    localparam int ReleaseLimit = 4;        // cycles allowed to see nrst high
    localparam int RunLimit = NumInstr + 8;
    localparam logic [31:0] NopWord = 32'h0000_0013;  // addi x0, x0, 0

    logic clk;
    logic nrst;
    rvIsaPkg::instrU instruction;
    logic [`RV_XLEN-1:0] dataFromMem;
    rvCorePkg::memReqS memReq;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] pc;

    rvCore uut (
        .clk(clk),
        .nrst(nrst),
        .instruction(instruction),
        .dataFromMem(dataFromMem),
        .memReq(memReq),
        .aluResult(aluResult),
        .pc(pc)
    );

    `include "rvCoreModel.svh"

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkWord(input string name, input logic [`RV_XLEN-1:0] expected,
                             input logic [`RV_XLEN-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            failRun("word value differs from model");
        end
    endtask

    task automatic checkMemReq(input string name, input rvCorePkg::memReqS expected,
                               input rvCorePkg::memReqS actual);
        if (actual !== expected)
        begin
            $display("ERROR %s expected r=%b w=%b addr=%h wdata=%h actual r=%b w=%b addr=%h wdata=%h",
                     name, expected.read, expected.write, expected.addr, expected.wdata,
                     actual.read, actual.write, actual.addr, actual.wdata);
            failRun("memory request differs from model");
        end
    endtask

    // legal instruction from the kept set, weighted over 16 slots
    task automatic genInstr(output logic [31:0] ins);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic alt;
        logic [11:0] immI;
        logic [12:0] offB;
        logic [20:0] offJ;
        int t;
        r = $urandom();
        s = $urandom();
        rd = s[4:0];
        rs1 = s[9:5];
        rs2 = s[14:10];
        f3 = s[17:15];
        alt = s[18];
        case (r[3:0])
            4'd0, 4'd1, 4'd2:
            begin
                alt = alt && (f3 == 3'b000 || f3 == 3'b101);  // sub, sra only
                ins = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd3, 4'd4, 4'd5:
            begin
                if (f3 == 3'b001)
                    immI = {7'b0000000, r[24:20]};  // slli
                else if (f3 == 3'b101)
                    immI = {alt ? 7'b0100000 : 7'b0000000, r[24:20]};  // srli / srai
                else
                    immI = r[31:20];
                ins = {immI, rs1, f3, rd, 7'b0010011};
            end
            4'd6:
                ins = {r[31:12], rd, 7'b0110111};  // lui
            4'd7, 4'd8:
                ins = {r[31:20], rs1, 3'b010, rd, 7'b0000011};  // lw
            4'd9, 4'd10, 4'd11:
                ins = {r[31:25], rs2, rs1, 3'b010, r[11:7], 7'b0100011};  // sw, shows a reg
            4'd12, 4'd13:
            begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;  // 010/011 unused, fold onto bltu/bgeu
                offB = {r[31:21], 2'b00};  // word multiple
                ins = {offB[12], offB[10:5], rs2, rs1, f3, offB[4:1], offB[11], 7'b1100011};
            end
            4'd14:
            begin
                offJ = {r[31:13], 2'b00};
                ins = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], rd, 7'b1101111};
            end
            default:
            begin
                rs1 = 5'd0;  // x0 always aligned
                for (t = 0; t < 8; t++)
                begin
                    s = $urandom();
                    if (modelRegs[s[4:0]][1:0] == 2'b00)
                        rs1 = s[4:0];
                end
                ins = {r[31:22], 2'b00, rs1, 3'b000, rd, 7'b1100111};  // jalr
            end
        endcase
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial
    begin
        logic [31:0] ins;
        logic [31:0] memWord;
        logic [31:0] expAlu;
        logic checkAlu;
        rvCorePkg::memReqS expReq;
        int waitCycles;
        int cycles;
        int retired;
        nrst = 1'b0;
        instruction = NopWord;
        dataFromMem = '0;
        void'($urandom(32'hdddf3f0f));
        modelReset();
        repeat (ResetCycles) @(posedge clk);
        nrst <= 1'b1;

        waitCycles = 0;
        while (nrst !== 1'b1)
        begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > ReleaseLimit)
                failRun("reset release never reached the DUT");
        end
        checkWord("reset pc", modelPc, pc);
        modelStep(NopWord, '0, expAlu, checkAlu, expReq);  // nop held over the release
        checkMemReq("reset memReq", expReq, memReq);

        cycles = 0;
        retired = 0;
        while (retired < NumInstr)
        begin
            genInstr(ins);
            memWord = $urandom();
            @(posedge clk);
            instruction <= ins;
            dataFromMem <= memWord;
            @(negedge clk);  // outputs settled mid-cycle
            cycles++;
            if (cycles > RunLimit)
                failRun("instruction stream did not finish in time");
            checkWord($sformatf("pc %0d ins %h", retired, ins), modelPc, pc);
            modelStep(ins, memWord, expAlu, checkAlu, expReq);
            checkMemReq($sformatf("memReq %0d ins %h", retired, ins), expReq, memReq);
            if (checkAlu)
                checkWord($sformatf("aluResult %0d ins %h", retired, ins), expAlu, aluResult);
            retired++;
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* logic/rvCore.sv */
// single-cycle RV32I core top
// decoder, register file, alu and pc; one instruction retires per clock
// write-back select and the word-wide memory request live here
`include "rvDefs_defs.svh"

module rvCore (
    input  logic clk,
    input  logic nrst,
    input  rvIsaPkg::instrU instruction,
    input  logic [`RV_XLEN-1:0] dataFromMem,
    output rvCorePkg::memReqS memReq,
    output logic [`RV_XLEN-1:0] aluResult,
    output logic [`RV_XLEN-1:0] pc
);

    rvCorePkg::ctrlS ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] linkAddr;
    logic [`RV_XLEN-1:0] wbData;
    logic branchTaken;

    instrDecoder decoder (
        .instruction(instruction),
        .ctrl(ctrl),
        .imm(imm)
    );

    regFile regs (
        .clk(clk),
        .nrst(nrst),
        .rs1(instruction.r.rs1),  // register fields via r-type view
        .rs2(instruction.r.rs2),
        .rd(instruction.r.rd),
        .writeEn(ctrl.regWrite),
        .writeData(wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    assign opB = ctrl.aluSrcImm ? imm : rs2Data;

    aluUnit alu (
        .aluOp(ctrl.aluOp),
        .opA(rs1Data),
        .opB(opB),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    pcUnit pcReg (
        .clk(clk),
        .nrst(nrst),
        .ctrl(ctrl),
        .branchTaken(branchTaken),
        .imm(imm),
        .rs1Data(rs1Data),
        .pc(pc),
        .linkAddr(linkAddr)
    );

    always_comb
    begin
        case (ctrl.wbSel)
            rvCorePkg::WB_MEM:  wbData = dataFromMem;  // lw, full word
            rvCorePkg::WB_IMM:  wbData = imm;          // lui
            rvCorePkg::WB_LINK: wbData = linkAddr;     // jal, jalr
            default:            wbData = aluResult;
        endcase
    end

    // level strobes, addr/wdata zeroed while idle
    always_comb
    begin
        memReq       = '0;
        memReq.read  = ctrl.memRead;
        memReq.write = ctrl.memWrite;
        if (ctrl.memRead || ctrl.memWrite)
        begin
            memReq.addr  = aluResult;  // rs1 + imm
            memReq.wdata = rs2Data;
        end
    end

endmodule

/* logic/pcUnit.sv */
// program counter
// next address from sequential flow, taken branch, jal or jalr; link = pc + 4
`include "rvDefs_defs.svh"

module pcUnit (
    input  logic clk,
    input  logic nrst,
    input  rvCorePkg::ctrlS ctrl,
    input  logic branchTaken,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] linkAddr
);

    logic [`RV_XLEN-1:0] nextPc;

    assign linkAddr = pc + `RV_XLEN'(`RV_INSTR_BYTES);

    always_comb
    begin
        if (ctrl.regJump)
            nextPc = (rs1Data + imm) & ~`RV_XLEN'(1);  // jalr clears bit 0
        else if (ctrl.jump || (ctrl.branch && branchTaken))
            nextPc = pc + imm;  // pc-relative
        else
            nextPc = linkAddr;
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            pc <= `RV_RESET_PC;
        else
            pc <= nextPc;
    end

    // targets from decoder and rs1 must keep fetch word aligned
    assert property (@(posedge clk) disable iff (!nrst) pc[1:0] == 2'b00);

endmodule

/* logic/regFile.sv */
// integer register file, 32 x 32
// two combinational read ports, one write port on the rising edge
// x0 always reads zero
`include "rvDefs_defs.svh"

module regFile (
    input  logic clk,
    input  logic nrst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1,
    input  logic [`RV_REG_ADDR_W-1:0] rs2,
    input  logic [`RV_REG_ADDR_W-1:0] rd,
    input  logic writeEn,
    input  logic [`RV_XLEN-1:0] writeData,
    output logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] rs2Data
);

    logic [`RV_XLEN-1:0] regs [0:`RV_REG_COUNT-1];  // x0 entry held at zero by the write guard

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn && rd != '0)  // writes to x0 dropped
        begin
            regs[rd] <= writeData;
        end
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // x0 stays zero on both ports, also right after a write aimed at it
    assert property (@(posedge clk) disable iff (!nrst)
        (rs1 == '0 |-> rs1Data == '0) and (rs2 == '0 |-> rs2Data == '0));

endmodule

/* logic/aluUnit.sv */
// integer alu
// add/sub, shifts, set-less-than and logic ops; branch compares drive branchTaken
`include "rvDefs_defs.svh"

module aluUnit (
    input  rvIsaPkg::aluOpE aluOp,
    input  logic [`RV_XLEN-1:0] opA,
    input  logic [`RV_XLEN-1:0] opB,
    output logic [`RV_XLEN-1:0] result,
    output logic branchTaken
);

    logic [4:0] shamt;
    logic ltSigned;
    logic ltUnsigned;
    logic equal;

    assign shamt      = opB[4:0];  // rs2[4:0] or imm[4:0]
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;
    assign equal      = opA == opB;

    always_comb
    begin
        result      = '0;
        branchTaken = 1'b0;
        case (aluOp)
            rvIsaPkg::ALU_ADD:  result = opA + opB;  // carry dropped
            rvIsaPkg::ALU_SUB:  result = opA - opB;
            rvIsaPkg::ALU_SLL:  result = opA << shamt;
            rvIsaPkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, ltSigned};
            rvIsaPkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, ltUnsigned};
            rvIsaPkg::ALU_XOR:  result = opA ^ opB;
            rvIsaPkg::ALU_SRL:  result = opA >> shamt;
            rvIsaPkg::ALU_SRA:  result = $unsigned($signed(opA) >>> shamt);  // sign fill
            rvIsaPkg::ALU_OR:   result = opA | opB;
            rvIsaPkg::ALU_AND:  result = opA & opB;
            rvIsaPkg::ALU_BEQ:  branchTaken = equal;
            rvIsaPkg::ALU_BNE:  branchTaken = !equal;
            rvIsaPkg::ALU_BLT:  branchTaken = ltSigned;
            rvIsaPkg::ALU_BGE:  branchTaken = !ltSigned;
            rvIsaPkg::ALU_BLTU: branchTaken = ltUnsigned;
            rvIsaPkg::ALU_BGEU: branchTaken = !ltUnsigned;
            default:
            begin
                result      = '0;
                branchTaken = 1'b0;
            end
        endcase
    end

endmodule

/* logic/instrDecoder.sv */
// instruction decoder
// opcode and funct fields to control word, alu op and immediate
// unsupported encodings decode to a nop
`include "rvDefs_defs.svh"

module instrDecoder (
    input  rvIsaPkg::instrU instruction,
    output rvCorePkg::ctrlS ctrl,
    output logic [`RV_XLEN-1:0] imm
);

    localparam rvCorePkg::ctrlS NopCtrl = '{
        regWrite:  1'b0,
        aluSrcImm: 1'b0,
        wbSel:     rvCorePkg::WB_ALU,
        memRead:   1'b0,
        memWrite:  1'b0,
        jump:      1'b0,
        branch:    1'b0,
        regJump:   1'b0,
        aluOp:     rvIsaPkg::ALU_ADD
    };

    logic [2:0] f3;
    logic [6:0] f7;
    logic isReg;
    logic f7Base;
    logic f7Alt;
    rvIsaPkg::aluOpE arithOp;
    logic arithOk;
    rvIsaPkg::aluOpE cmpOp;
    logic cmpOk;
    rvCorePkg::ctrlS dec;
    logic legal;

    assign f3     = instruction.r.funct3;
    assign f7     = instruction.r.funct7;  // imm[11:5] for op-imm
    assign isReg  = (instruction.r.opcode == rvIsaPkg::OP);
    assign f7Base = (f7 == rvIsaPkg::F7_BASE);
    assign f7Alt  = (f7 == rvIsaPkg::F7_ALT);

    // arithmetic op, shared by OP and OP_IMM
    always_comb
    begin
        arithOp = rvIsaPkg::ALU_ADD;
        arithOk = !isReg || f7Base;  // funct7 is immediate bits for op-imm
        case (f3)
            rvIsaPkg::F3_ADD_SUB:
            begin
                arithOp = (isReg && f7Alt) ? rvIsaPkg::ALU_SUB : rvIsaPkg::ALU_ADD;
                arithOk = !isReg || f7Base || f7Alt;
            end
            rvIsaPkg::F3_SLL:
            begin
                arithOp = rvIsaPkg::ALU_SLL;
                arithOk = f7Base;  // slli too
            end
            rvIsaPkg::F3_SLT:  arithOp = rvIsaPkg::ALU_SLT;
            rvIsaPkg::F3_SLTU: arithOp = rvIsaPkg::ALU_SLTU;
            rvIsaPkg::F3_XOR:  arithOp = rvIsaPkg::ALU_XOR;
            rvIsaPkg::F3_SRL_SRA:
            begin
                arithOp = f7Alt ? rvIsaPkg::ALU_SRA : rvIsaPkg::ALU_SRL;
                arithOk = f7Base || f7Alt;
            end
            rvIsaPkg::F3_OR:   arithOp = rvIsaPkg::ALU_OR;
            rvIsaPkg::F3_AND:  arithOp = rvIsaPkg::ALU_AND;
            default:           arithOk = 1'b0;
        endcase
    end

    // branch compare select
    always_comb
    begin
        cmpOp = rvIsaPkg::ALU_BEQ;
        cmpOk = 1'b1;
        case (f3)
            rvIsaPkg::F3_BEQ:  cmpOp = rvIsaPkg::ALU_BEQ;
            rvIsaPkg::F3_BNE:  cmpOp = rvIsaPkg::ALU_BNE;
            rvIsaPkg::F3_BLT:  cmpOp = rvIsaPkg::ALU_BLT;
            rvIsaPkg::F3_BGE:  cmpOp = rvIsaPkg::ALU_BGE;
            rvIsaPkg::F3_BLTU: cmpOp = rvIsaPkg::ALU_BLTU;
            rvIsaPkg::F3_BGEU: cmpOp = rvIsaPkg::ALU_BGEU;
            default:           cmpOk = 1'b0;  // 010, 011 unused
        endcase
    end

    // control word per opcode
    always_comb
    begin
        dec   = NopCtrl;
        legal = 1'b1;
        case (instruction.r.opcode)
            rvIsaPkg::OP:
            begin
                dec.regWrite = 1'b1;
                dec.aluOp    = arithOp;
                legal        = arithOk;
            end
            rvIsaPkg::OP_IMM:
            begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = arithOp;
                legal         = arithOk;
            end
            rvIsaPkg::LOAD:
            begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;  // addr = rs1 + imm
                dec.memRead   = 1'b1;
                dec.wbSel     = rvCorePkg::WB_MEM;
                legal         = (f3 == rvIsaPkg::F3_WORD);
            end
            rvIsaPkg::STORE:
            begin
                dec.aluSrcImm = 1'b1;
                dec.memWrite  = 1'b1;
                legal         = (f3 == rvIsaPkg::F3_WORD);
            end
            rvIsaPkg::BRANCH:
            begin
                dec.branch = 1'b1;
                dec.aluOp  = cmpOp;  // rs1 vs rs2
                legal      = cmpOk;
            end
            rvIsaPkg::JAL:
            begin
                dec.regWrite = 1'b1;
                dec.jump     = 1'b1;
                dec.wbSel    = rvCorePkg::WB_LINK;
            end
            rvIsaPkg::JALR:
            begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.jump      = 1'b1;
                dec.regJump   = 1'b1;
                dec.wbSel     = rvCorePkg::WB_LINK;
                legal         = (f3 == rvIsaPkg::F3_JALR);
            end
            rvIsaPkg::LUI:
            begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.wbSel     = rvCorePkg::WB_IMM;
            end
            default: legal = 1'b0;
        endcase
        ctrl = legal ? dec : NopCtrl;
    end

    // immediate, read through the format view of the opcode
    always_comb
    begin
        case (instruction.r.opcode)
            rvIsaPkg::OP_IMM, rvIsaPkg::LOAD, rvIsaPkg::JALR:
                imm = {{20{instruction.i.imm[11]}}, instruction.i.imm};
            rvIsaPkg::STORE:
                imm = {{20{instruction.s.immHi[6]}}, instruction.s.immHi, instruction.s.immLo};
            rvIsaPkg::BRANCH:
                imm = {{19{instruction.b.imm12}}, instruction.b.imm12, instruction.b.imm11,
                       instruction.b.imm10to5, instruction.b.imm4to1, 1'b0};
            rvIsaPkg::LUI:
                imm = {instruction.u.imm, 12'b0};
            rvIsaPkg::JAL:
                imm = {{11{instruction.j.imm20}}, instruction.j.imm20, instruction.j.imm19to12,
                       instruction.j.imm11, instruction.j.imm10to1, 1'b0};
            default:
                imm = '0;  // OP and unknown
        endcase
    end

endmodule

/* logic/rvCorePkg.sv */
// core-internal signal bundles
// control word from the decoder, write-back source and memory request
`include "rvDefs_defs.svh"

package rvCorePkg;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_IMM  = 2'b10,  // lui
        WB_LINK = 2'b11   // jal, jalr
    } wbSelE;

    typedef struct packed {
        logic regWrite;     // rd gets written
        logic aluSrcImm;    // opB is imm instead of rs2
        wbSelE wbSel;
        logic memRead;
        logic memWrite;
        logic jump;         // unconditional, jal or jalr
        logic branch;       // conditional on branchTaken
        logic regJump;      // target from rs1, jalr
        rvIsaPkg::aluOpE aluOp;
    } ctrlS;

    typedef struct packed {
        logic read;
        logic write;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
    } memReqS;

endpackage

/* logic/rvIsaPkg.sv */
// RV32I instruction set description
// opcodes, funct codes, instruction formats and ALU operations
`include "rvDefs_defs.svh"

package rvIsaPkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register alu
        OP_IMM = 7'b0010011,  // register-immediate alu
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_BEQ  = 4'd10,  // compares only drive branchTaken
        ALU_BNE  = 4'd11,
        ALU_BLT  = 4'd12,
        ALU_BGE  = 4'd13,
        ALU_BLTU = 4'd14,
        ALU_BGEU = 4'd15
    } aluOpE;

    // funct3, arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // funct3, branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    // funct3, memory and jalr
    localparam logic [2:0] F3_WORD = 3'b010;  // lw / sw only
    localparam logic [2:0] F3_JALR = 3'b000;
    // funct7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcodeE opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0] imm;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcodeE opcode;
    } iTypeS;

    typedef struct packed {
        logic [6:0] immHi;  // imm[11:5]
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;  // imm[4:0]
        opcodeE opcode;
    } sTypeS;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        opcodeE opcode;
    } bTypeS;

    typedef struct packed {
        logic [19:0] imm;  // imm[31:12]
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcodeE opcode;
    } uTypeS;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcodeE opcode;
    } jTypeS;

    // one word, several views
    typedef union packed {
        rTypeS r;
        iTypeS i;
        sTypeS s;
        bTypeS b;
        uTypeS u;
        jTypeS j;
    } instrU;

endpackage

/* logic/rvDefs_defs.svh */
// RV32I core constants
// widths, register count, reset vector and pc step shared by the RTL
`ifndef RV_DEFS_DEFS_SVH
`define RV_DEFS_DEFS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers x0..x31
`define RV_REG_COUNT 32

// register index width
`define RV_REG_ADDR_W 5

// pc after reset
`define RV_RESET_PC 32'h0000_0000

// bytes per instruction, sequential pc step
`define RV_INSTR_BYTES 4

`endif
